// ==== filelist.f ====
+incdir+common
common/idiv_pkg.sv
idiv/idiv_controller.sv
idiv/idiv_datapath.sv
src/idiv_top.sv
tests/idiv_props.sv
tests/idiv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module idiv_tb -Mdir obj_dir -f filelist.f

./obj_dir/Vidiv_tb | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tests/idiv_tb.sv ====
`timescale 1ns/1ps
`include "idiv_cfg.svh"

module idiv_tb;

	localparam int W = `IDIV_WIDTH;
	localparam int N_RANDOM = 200;
	localparam int N_OPS = 13 + N_RANDOM + 2;
	localparam int MAX_STALL = 7;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES = N_OPS * (W + 9 + MAX_STALL + 4) + RESET_CYCLES;
	localparam logic [W-1:0] MIN_VAL = {1'b1, {(W-1){1'b0}}};

	logic                 clk_i = 1'b0;
	logic                 reset_i;
	logic                 v_i;
	logic                 yumi_i;
	logic                 ready_o;
	logic                 v_o;
	idiv_pkg::idiv_req_t  req_i;
	idiv_pkg::idiv_resp_t resp_o;

	// expected results written by the stimulus and read by the checker
	idiv_pkg::idiv_resp_t exp_mem [N_OPS];
	string                name_mem [N_OPS];
	int                   exp_wr = 0;
	int                   chk_idx = 0;
	int                   fail_cnt = 0;
	int                   stray_cnt = 0;
	int                   stall_err_cnt = 0;
	int                   cycle_cnt = 0;
	logic                 chk_ok;
	logic [31:0]          rng = 32'hc11a;

	idiv_top DUT (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.v_i     (v_i),
		.req_i   (req_i),
		.ready_o (ready_o),
		.v_o     (v_o),
		.resp_o  (resp_o),
		.yumi_i  (yumi_i)
	);

	bind idiv_top idiv_props u_props (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.v_i     (v_i),
		.ready_o (ready_o),
		.v_o     (v_o),
		.yumi_i  (yumi_i),
		.resp_o  (resp_o)
	);

	always #4 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// risc-v results with the corner cases handled before the operators
	function automatic idiv_pkg::idiv_resp_t ref_divide(input idiv_pkg::idiv_req_t r);
		idiv_pkg::idiv_resp_t res;
		if (r.divisor == '0) begin
			res.quotient  = '1;
			res.remainder = r.dividend;
		end else if (r.signed_div && r.dividend == MIN_VAL && r.divisor == '1) begin
			res.quotient  = MIN_VAL;
			res.remainder = '0;
		end else if (r.signed_div) begin
			res.quotient  = $signed(r.dividend) / $signed(r.divisor);
			res.remainder = $signed(r.dividend) % $signed(r.divisor);
		end else begin
			res.quotient  = r.dividend / r.divisor;
			res.remainder = r.dividend % r.divisor;
		end
		return res;
	endfunction

	task automatic push_expect(input string name, input idiv_pkg::idiv_req_t r);
		if (exp_wr < N_OPS) begin
			exp_mem[exp_wr]  = ref_divide(r);
			name_mem[exp_wr] = name;
			exp_wr           = exp_wr + 1;
		end
	endtask

	task automatic send_req(input idiv_pkg::idiv_req_t r);
		v_i   = 1'b1;
		req_i = r;
		while (!ready_o) @(negedge clk_i);
		@(negedge clk_i);
		v_i = 1'b0;
	endtask

	// hold yumi_i off for stall cycles while a bogus request is offered
	task automatic collect(input string name, input int stall, input logic hold_req);
		while (!v_o) @(negedge clk_i);
		for (int k = 0; k < stall; k++) begin
			if (!hold_req) begin
				v_i   = 1'b1;
				req_i = '{dividend: W'(k + 1), divisor: '0, signed_div: 1'b1};
			end
			@(negedge clk_i);
			assert (v_o && !ready_o) else begin
				$display("%s: v_o fell or ready_o rose in stall cycle %0d", name, k);
				stall_err_cnt = stall_err_cnt + 1;
			end
		end
		if (!hold_req) begin
			v_i = 1'b0;
		end
		yumi_i = 1'b1;
		@(negedge clk_i);
		yumi_i = 1'b0;
	endtask

	task automatic run_op(input string name, input logic [W-1:0] a, input logic [W-1:0] b,
			input logic sgn, input int stall);
		idiv_pkg::idiv_req_t r;
		r = '{dividend: a, divisor: b, signed_div: sgn};
		push_expect(name, r);
		send_req(r);
		collect(name, stall, 1'b0);
	endtask

	// ==========================================================================
	// result check on each consuming edge
	// ==========================================================================

	always @(posedge clk_i) begin
		if (!reset_i && v_o && yumi_i) begin
			if (chk_idx >= exp_wr) begin
				$display("result handed out with no request outstanding");
				stray_cnt = stray_cnt + 1;
			end else begin
				chk_ok = 1'b1;
				assert (resp_o.quotient == exp_mem[chk_idx].quotient) else begin
					$display("** Error %s quotient: expected 0x%h, actual 0x%h",
						name_mem[chk_idx], exp_mem[chk_idx].quotient, resp_o.quotient);
					chk_ok = 1'b0;
				end
				assert (resp_o.remainder == exp_mem[chk_idx].remainder) else begin
					$display("** Error %s remainder: expected 0x%h, actual 0x%h",
						name_mem[chk_idx], exp_mem[chk_idx].remainder, resp_o.remainder);
					chk_ok = 1'b0;
				end
				if (chk_ok) begin
					$display("%s passed", name_mem[chk_idx]);
				end else begin
					$display("%s failed", name_mem[chk_idx]);
					fail_cnt = fail_cnt + 1;
				end
				chk_idx = chk_idx + 1;
			end
		end
	end

	always @(posedge clk_i) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ==========================================================================
	// stimulus
	// ==========================================================================

	initial begin : stimulus
		idiv_pkg::idiv_req_t busy_a;
		idiv_pkg::idiv_req_t busy_b;
		logic [W-1:0]        a;
		logic [W-1:0]        b;
		logic [31:0]         mode;
		reset_i = 1'b1;
		v_i     = 1'b0;
		yumi_i  = 1'b0;
		req_i   = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b0;

		run_op("u_zero_dividend", '0, W'(7), 1'b0, 0);
		run_op("u_div_one", W'(32'h12345678), W'(1), 1'b0, 1);
		run_op("u_equal", W'(32'hdeadbeef), W'(32'hdeadbeef), 1'b0, 0);
		run_op("u_small", W'(5), W'(9), 1'b0, 2);
		run_op("u_max_by_3", '1, W'(3), 1'b0, 0);
		run_op("u_by_max", W'(100), '1, 1'b0, 0);

		// all four sign pairs, then the overflow case
		run_op("s_pos_pos", W'(100), W'(7), 1'b1, 0);
		run_op("s_neg_pos", -W'(100), W'(7), 1'b1, 1);
		run_op("s_pos_neg", W'(100), -W'(7), 1'b1, 0);
		run_op("s_neg_neg", -W'(100), -W'(7), 1'b1, 3);
		run_op("s_min_by_neg1", MIN_VAL, '1, 1'b1, 0);

		run_op("u_div_zero", W'(32'h89abcdef), '0, 1'b0, 0);
		run_op("u_zero_by_zero", '0, '0, 1'b0, 1);

		for (int i = 0; i < N_RANDOM; i++) begin
			rng  = xorshift32(rng);
			a    = W'(rng);
			rng  = xorshift32(rng);
			b    = W'(rng);
			rng  = xorshift32(rng);
			mode = rng;
			// short divisors now and then for long quotients
			if (mode[5]) begin
				b = b >> mode[4:0];
			end
			if (mode[8] && b == '0) begin
				b = W'(1);
			end
			run_op($sformatf("rand_%0d", i), a, b, mode[8], int'(mode[14:12]));
		end

		// second request waits with v_i high while the first is busy
		busy_a = '{dividend: -W'(1000), divisor: W'(33), signed_div: 1'b1};
		busy_b = '{dividend: W'(32'hfedcba98), divisor: W'(77), signed_div: 1'b0};
		push_expect("busy_first", busy_a);
		push_expect("busy_second", busy_b);
		send_req(busy_a);
		v_i   = 1'b1;
		req_i = busy_b;
		collect("busy_first", 3, 1'b1);
		send_req(busy_b);
		collect("busy_second", 0, 1'b0);

		repeat (2) @(negedge clk_i);
		$display("tests run %0d, failed %0d, stray results %0d, stall errors %0d",
			chk_idx, fail_cnt, stray_cnt, stall_err_cnt);
		if (chk_idx != N_OPS) begin
			$display("only %0d of %0d results came back", chk_idx, N_OPS);
		end
		if (fail_cnt == 0 && stray_cnt == 0 && stall_err_cnt == 0 && chk_idx == N_OPS) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== tests/idiv_props.sv ====
`timescale 1ns/1ps
`include "idiv_cfg.svh"

module idiv_props (
	input logic                 clk_i,
	input logic                 reset_i,
	input logic                 v_i,
	input logic                 ready_o,
	input logic                 v_o,
	input logic                 yumi_i,
	input idiv_pkg::idiv_resp_t resp_o
);

	localparam int LATENCY = `IDIV_WIDTH + 9;

	// edges counted from the accepting edge until v_o rises
	int lat_cnt_r;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			lat_cnt_r <= 0;
		end else if (v_i && ready_o) begin
			lat_cnt_r <= 1;
		end else if (lat_cnt_r != 0 && !v_o && !ready_o) begin
			lat_cnt_r <= lat_cnt_r + 1;
		end
	end

	// ==========================================================================
	// handshake and latency
	// ==========================================================================

	reset_state: assert property (@(posedge clk_i) $fell(reset_i) |-> (ready_o && !v_o))
		else $error("ready_o low or v_o high right after reset");

	latency: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(v_o) |-> (lat_cnt_r == LATENCY))
		else $error("v_o rose after %0d edges instead of %0d", lat_cnt_r, LATENCY);

	resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		(v_o && !yumi_i) |=> (v_o && $stable(resp_o)))
		else $error("result dropped or changed while waiting for yumi_i");

	ready_excl: assert property (@(posedge clk_i) disable iff (reset_i) !(ready_o && v_o))
		else $error("ready_o and v_o high together");

	yumi_legal: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
		else $error("yumi_i high without v_o");

endmodule

// ==== src/idiv_top.sv ====
`timescale 1ns/1ps

module idiv_top (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 v_i,
	input  idiv_pkg::idiv_req_t  req_i,
	output logic                 ready_o,
	output logic                 v_o,
	output idiv_pkg::idiv_resp_t resp_o,
	input  logic                 yumi_i
);

	idiv_pkg::idiv_ctrl_t   ctrl;
	idiv_pkg::idiv_status_t status;

	// sequencing
	idiv_controller u_controller (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.v_i      (v_i),
		.ready_o  (ready_o),
		.status_i (status),
		.ctrl_o   (ctrl),
		.v_o      (v_o),
		.yumi_i   (yumi_i)
	);

	// operand registers and shared adder
	idiv_datapath u_datapath (
		.clk_i    (clk_i),
		.req_i    (req_i),
		.ctrl_i   (ctrl),
		.status_o (status),
		.resp_o   (resp_o)
	);

endmodule

// ==== idiv/idiv_datapath.sv ====
`timescale 1ns/1ps
`include "idiv_cfg.svh"

module idiv_datapath (
	input  logic                   clk_i,
	input  idiv_pkg::idiv_req_t    req_i,
	input  idiv_pkg::idiv_ctrl_t   ctrl_i,
	output idiv_pkg::idiv_status_t status_o,
	output idiv_pkg::idiv_resp_t   resp_o
);

	localparam int W = `IDIV_WIDTH;

	idiv_pkg::idiv_req_t req_r;

	// one extra bit on top for the sign
	logic [W:0] opa_r;
	logic [W:0] opb_r;
	logic [W:0] opc_r;

	logic [W:0] opa_mux;
	logic [W:0] opb_mux;
	logic [W:0] opc_mux;

	logic [W:0] opa_in;
	logic [W:0] opb_in;
	logic [W:0] add_out;

	logic divisor_msb;
	logic dividend_msb;

	// ==========================================================================
	// input latch
	// ==========================================================================

	always_ff @(posedge clk_i) begin
		if (ctrl_i.latch_inputs) begin
			req_r <= req_i;
		end
	end

	// extension bit is zero for unsigned
	assign divisor_msb  = req_r.signed_div & req_r.divisor[W-1];
	assign dividend_msb = req_r.signed_div & req_r.dividend[W-1];

	// ==========================================================================
	// shared adder
	// ==========================================================================

	// invert first, then clear
	assign opa_in = (opa_r ^ {(W+1){ctrl_i.opa_inv}}) & {(W+1){ctrl_i.opa_clr_l}};
	assign opb_in = (opb_r ^ {(W+1){ctrl_i.opb_inv}}) & {(W+1){ctrl_i.opb_clr_l}};

	assign add_out = opa_in + opb_in + {{W{1'b0}}, ctrl_i.adder_cin};

	// ==========================================================================
	// source selects
	// ==========================================================================

	assign opa_mux = ctrl_i.opa_sel ? {divisor_msb, req_r.divisor} : add_out;

	always_comb begin
		case (ctrl_i.opb_sel)
			idiv_pkg::OPB_OPC: opb_mux = opc_r;
			idiv_pkg::OPB_ADD: opb_mux = add_out;
			// partial remainder shifts left, next dividend bit enters
			default:           opb_mux = {add_out[W-1:0], opc_r[W]};
		endcase
	end

	always_comb begin
		case (ctrl_i.opc_sel)
			idiv_pkg::OPC_ADD:      opc_mux = add_out;
			idiv_pkg::OPC_DIVIDEND: opc_mux = {dividend_msb, req_r.dividend};
			// quotient bit is set when the step stayed non-negative
			default:                opc_mux = {opc_r[W-1:0], ~add_out[W]};
		endcase
	end

	// ==========================================================================
	// operand registers
	// ==========================================================================

	always_ff @(posedge clk_i) begin
		if (ctrl_i.opa_ld) begin
			opa_r <= opa_mux;
		end
		if (ctrl_i.opb_ld) begin
			opb_r <= opb_mux;
		end
		if (ctrl_i.opc_ld) begin
			opc_r <= opc_mux;
		end
	end

	assign status_o.signed_div_r = req_r.signed_div;
	assign status_o.adder_neg    = add_out[W];
	assign status_o.opa_neg      = opa_r[W];
	assign status_o.opc_neg      = opc_r[W];

	// quotient ends in opC, remainder in opA
	assign resp_o.quotient  = opc_r[W-1:0];
	assign resp_o.remainder = opa_r[W-1:0];

endmodule

// ==== idiv/idiv_controller.sv ====
`timescale 1ns/1ps
`include "idiv_cfg.svh"

module idiv_controller (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   v_i,
	output logic                   ready_o,
	input  idiv_pkg::idiv_status_t status_i,
	output idiv_pkg::idiv_ctrl_t   ctrl_o,
	output logic                   v_o,
	input  logic                   yumi_i
);

	localparam int CNT_W = `IDIV_CNT_W;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`IDIV_WIDTH);

	idiv_pkg::idiv_state_e state_r;
	idiv_pkg::idiv_state_e state_n;

	logic [CNT_W-1:0] cnt_r;
	logic             q_neg_r;
	logic             r_neg_r;
	logic             add_neg_last_r;
	logic             neg_ld;

	// ==========================================================================
	// state and flag registers
	// ==========================================================================

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_r        <= idiv_pkg::WAIT;
			cnt_r          <= '0;
			q_neg_r        <= 1'b0;
			r_neg_r        <= 1'b0;
			add_neg_last_r <= 1'b0;
			v_o            <= 1'b0;
		end else begin
			state_r        <= state_n;
			// sign of the previous step picks add or subtract
			add_neg_last_r <= status_i.adder_neg;
			v_o            <= (state_n == idiv_pkg::DONE);

			if (state_r == idiv_pkg::SHIFT) begin
				cnt_r <= '0;
			end else if (state_r == idiv_pkg::CALC) begin
				cnt_r <= cnt_r + 1'b1;
			end

			if (neg_ld) begin
				// quotient flips when operand signs differ
				q_neg_r <= (status_i.opa_neg ^ status_i.opc_neg) & status_i.signed_div_r;
				// remainder follows the dividend sign
				r_neg_r <= status_i.opc_neg & status_i.signed_div_r;
			end
		end
	end

	// ==========================================================================
	// next state and datapath commands
	// ==========================================================================

	always_comb begin
		// defaults are the per-bit non-restoring step
		ctrl_o.opa_sel      = 1'b0;
		ctrl_o.opa_ld       = 1'b0;
		ctrl_o.opa_inv      = ~add_neg_last_r;
		ctrl_o.opa_clr_l    = 1'b1;
		ctrl_o.opb_sel      = idiv_pkg::OPB_SHIFT;
		ctrl_o.opb_ld       = 1'b1;
		ctrl_o.opb_inv      = 1'b0;
		ctrl_o.opb_clr_l    = 1'b1;
		ctrl_o.opc_sel      = idiv_pkg::OPC_SHIFT;
		ctrl_o.opc_ld       = 1'b1;
		ctrl_o.latch_inputs = 1'b0;
		ctrl_o.adder_cin    = ~add_neg_last_r;
		neg_ld              = 1'b0;
		state_n             = state_r;

		case (state_r)
			idiv_pkg::WAIT: begin
				ctrl_o.latch_inputs = 1'b1;
				ctrl_o.opb_ld       = 1'b0;
				ctrl_o.opc_ld       = 1'b0;
				if (v_i) begin
					state_n = idiv_pkg::START;
				end
			end

			// divisor into opA, dividend into opC, sign extended
			idiv_pkg::START: begin
				ctrl_o.opa_sel = 1'b1;
				ctrl_o.opa_ld  = 1'b1;
				ctrl_o.opb_ld  = 1'b0;
				ctrl_o.opc_sel = idiv_pkg::OPC_DIVIDEND;
				state_n        = idiv_pkg::NEG0;
			end

			// |divisor| into opA, dividend copied to opB
			idiv_pkg::NEG0: begin
				ctrl_o.opa_inv   = 1'b1;
				ctrl_o.opa_ld    = status_i.opa_neg & status_i.signed_div_r;
				ctrl_o.opb_clr_l = 1'b0;
				ctrl_o.opb_sel   = idiv_pkg::OPB_OPC;
				ctrl_o.opc_ld    = 1'b0;
				ctrl_o.adder_cin = 1'b1;
				neg_ld           = 1'b1;
				state_n          = idiv_pkg::NEG1;
			end

			// |dividend| back into opC
			idiv_pkg::NEG1: begin
				ctrl_o.opa_clr_l = 1'b0;
				ctrl_o.opb_inv   = 1'b1;
				ctrl_o.opb_ld    = 1'b0;
				ctrl_o.opc_sel   = idiv_pkg::OPC_ADD;
				ctrl_o.opc_ld    = status_i.opc_neg & status_i.signed_div_r;
				ctrl_o.adder_cin = 1'b1;
				state_n          = idiv_pkg::SHIFT;
			end

			// zero partial remainder, first dividend bit moves up
			idiv_pkg::SHIFT: begin
				ctrl_o.opa_clr_l = 1'b0;
				ctrl_o.opb_clr_l = 1'b0;
				ctrl_o.adder_cin = 1'b0;
				state_n          = idiv_pkg::CALC;
			end

			idiv_pkg::CALC: begin
				if (cnt_r == LAST_CNT) begin
					// keep the final remainder unshifted
					ctrl_o.opb_sel = idiv_pkg::OPB_ADD;
					state_n        = idiv_pkg::REPAIR;
				end
			end

			// add the divisor back if the remainder went negative
			idiv_pkg::REPAIR: begin
				ctrl_o.opa_inv   = 1'b0;
				ctrl_o.opb_sel   = idiv_pkg::OPB_ADD;
				ctrl_o.opb_ld    = add_neg_last_r;
				ctrl_o.opc_ld    = 1'b0;
				ctrl_o.adder_cin = 1'b0;
				state_n          = idiv_pkg::REMAIN;
			end

			// signed remainder into opA, quotient copied to opB
			idiv_pkg::REMAIN: begin
				ctrl_o.opa_ld    = 1'b1;
				ctrl_o.opa_clr_l = 1'b0;
				ctrl_o.opb_sel   = idiv_pkg::OPB_OPC;
				ctrl_o.opb_inv   = r_neg_r;
				ctrl_o.opc_ld    = 1'b0;
				ctrl_o.adder_cin = r_neg_r;
				state_n          = idiv_pkg::QUOT;
			end

			// negated quotient into opC when needed
			idiv_pkg::QUOT: begin
				ctrl_o.opa_clr_l = 1'b0;
				ctrl_o.opb_inv   = 1'b1;
				ctrl_o.opb_ld    = 1'b0;
				ctrl_o.opc_sel   = idiv_pkg::OPC_ADD;
				ctrl_o.opc_ld    = q_neg_r;
				ctrl_o.adder_cin = 1'b1;
				state_n          = idiv_pkg::DONE;
			end

			// hold result until consumed
			idiv_pkg::DONE: begin
				ctrl_o.opb_ld = 1'b0;
				ctrl_o.opc_ld = 1'b0;
				if (yumi_i) begin
					state_n = idiv_pkg::WAIT;
				end
			end

			default: begin
				state_n = idiv_pkg::WAIT;
			end
		endcase
	end

	assign ready_o = (state_r == idiv_pkg::WAIT);

endmodule

// ==== common/idiv_pkg.sv ====
`include "idiv_cfg.svh"

package idiv_pkg;

	// ==========================================================================
	// request and response
	// ==========================================================================

	typedef struct packed {
		logic [`IDIV_WIDTH-1:0] dividend;
		logic [`IDIV_WIDTH-1:0] divisor;
		logic                   signed_div;
	} idiv_req_t;

	typedef struct packed {
		logic [`IDIV_WIDTH-1:0] quotient;
		logic [`IDIV_WIDTH-1:0] remainder;
	} idiv_resp_t;

	// ==========================================================================
	// register source selects
	// ==========================================================================

	// opB: shifted partial remainder, quotient copy, or raw adder result
	typedef enum logic [1:0] {
		OPB_SHIFT,
		OPB_OPC,
		OPB_ADD
	} opb_sel_e;

	// opC: quotient bit shift, adder result, or latched dividend
	typedef enum logic [1:0] {
		OPC_SHIFT,
		OPC_ADD,
		OPC_DIVIDEND
	} opc_sel_e;

	// controller to datapath
	typedef struct packed {
		logic     opa_sel;
		logic     opa_ld;
		logic     opa_inv;
		logic     opa_clr_l;
		opb_sel_e opb_sel;
		logic     opb_ld;
		logic     opb_inv;
		logic     opb_clr_l;
		opc_sel_e opc_sel;
		logic     opc_ld;
		logic     latch_inputs;
		logic     adder_cin;
	} idiv_ctrl_t;

	// datapath back to controller
	typedef struct packed {
		logic signed_div_r;
		logic adder_neg;
		logic opa_neg;
		logic opc_neg;
	} idiv_status_t;

	typedef enum logic [3:0] {
		WAIT,
		START,
		NEG0,
		NEG1,
		SHIFT,
		CALC,
		REPAIR,
		REMAIN,
		QUOT,
		DONE
	} idiv_state_e;

endpackage

// ==== common/idiv_cfg.svh ====
`ifndef IDIV_CFG_SVH
`define IDIV_CFG_SVH

// ==========================================================================
// divider sizing
// ==========================================================================

// operand width in bits
`define IDIV_WIDTH 32

// bit counter width, wide enough to hold IDIV_WIDTH itself
`define IDIV_CNT_W ($clog2(`IDIV_WIDTH + 1))

`endif
